// File: dv/aqed_lockid_assert.sv
`timescale 1ns/1ps

module aqed_lockid_assert (
  input logic                     clk,
  input logic                     arst_n,
  input logic                     in_valid,
  input logic                     out_valid,
  input logic                     acq_valid,
  input aqed_lock_pkg::lock_key_t acq_key
);

  int fail_cnt;

  initial fail_cnt = 0;

  // Every request leaves exactly two edges after it was sampled
  a_req_to_res: assert property (@(posedge clk) disable iff (!arst_n)
    $past(in_valid, 2) |-> out_valid)
    else begin
      fail_cnt++;
      $error("a request produced no result two cycles later");
    end

  a_res_from_req: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> $past(in_valid, 2))
    else begin
      fail_cnt++;
      $error("a result appeared without a request two cycles earlier");
    end

  a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
      fail_cnt++;
      $error("out_valid was high during reset");
    end

  // The second of two identical back-to-back results sees the first one's
  // acquire as busy, so one key is never taken on two cycles in a row
  a_acq_no_repeat: assert property (@(posedge clk) disable iff (!arst_n)
    acq_valid && $past(acq_valid) |-> acq_key != $past(acq_key))
    else begin
      fail_cnt++;
      $error("the same key was acquired on two consecutive cycles");
    end

endmodule

bind aqed_lockid_top aqed_lockid_assert u_assert (
  .clk       (clk),
  .arst_n    (arst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .acq_valid (acq_valid),
  .acq_key   (acq_key)
);

// File: include/aqed_lockid_model.svh
`ifndef AQED_LOCKID_MODEL_SVH
`define AQED_LOCKID_MODEL_SVH

// Bit-serial CRC-12, MSB first, zero initial value
// The generator is x^12 plus the low terms 12'hf13
function automatic logic [11:0] model_crc12(input logic [15:0] lockid);
  logic [11:0] crc;
  logic        fb;
  crc = '0;
  for (int i = 15; i >= 0; i--) begin
    fb  = crc[11] ^ lockid[i];
    crc = {crc[10:0], 1'b0};
    if (fb) begin
      crc = crc ^ 12'hf13;
    end
  end
  return crc;
endfunction

// Shift/xor/add mix on a w-bit value, done in integer arithmetic
function automatic int unsigned model_mix(input int unsigned h, input int unsigned w,
                                          input int unsigned a, input int unsigned b,
                                          input int unsigned c, input int unsigned d,
                                          input int unsigned e);
  int unsigned m;
  int unsigned x;
  m = (32'd1 << w) - 1;
  x = h & m;
  x = x ^ (x >> a);
  x = x ^ (x >> b);
  x = (x + (x << c)) & m;
  x = x ^ (x >> d);
  x = x ^ (x >> e);
  return x;
endfunction

// Expected compressed lock ID for a given width code
function automatic logic [15:0] model_lockid(input logic [2:0] code, input logic [15:0] lockid);
  int unsigned h;
  int unsigned w;
  int unsigned r;
  h = model_crc12(lockid);
  w = aqed_lock_pkg::mix_base_w + code;
  case (code)
    3'd1:    r = model_mix(h, w, 2, 1, 3, 4, 2);
    3'd2:    r = model_mix(h, w, 1, 2, 4, 2, 3);
    3'd3:    r = model_mix(h, w, 1, 2, 4, 2, 4);
    3'd4:    r = model_mix(h, w, 1, 2, 4, 3, 5);
    3'd5:    r = model_mix(h, w, 2, 1, 5, 5, 2);
    3'd6:    r = model_mix(h, w, 1, 2, 5, 5, 3);
    3'd7:    r = model_mix(h, w, 2, 1, 5, 6, 3);
    default: r = lockid;
  endcase
  return r[15:0];
endfunction

`endif

// File: dv/aqed_lockid_tb.sv
`timescale 1ns/1ps

module aqed_lockid_tb;

  localparam int reset_cycles = 8;
  localparam logic [31:0] lfsr_seed = 32'h4318_a7c2;

  // Cycle budget per test in run order, with the tracker cleanup included
  localparam int t_pass  = 20;
  localparam int t_width = 90;
  localparam int t_cfg   = 20;
  localparam int t_b2b   = 15;
  localparam int t_rel   = 25;
  localparam int t_full  = 30;
  localparam int timeout_cycles =
    2 * (reset_cycles + t_pass + t_width + t_cfg + t_b2b + t_rel + t_full);

  logic                     clk;
  logic                     arst_n;
  logic                     cfg_we;
  aqed_lock_pkg::cfg_wr_t   cfg_wr;
  logic                     in_valid;
  aqed_lock_pkg::lock_req_t in_req;
  logic                     rel_valid;
  aqed_lock_pkg::lock_key_t rel_key;
  logic                     out_valid;
  aqed_lock_pkg::lock_res_t out_res;

  logic [31:0] lfsr_state;
  logic [aqed_lock_pkg::width_code_w-1:0] exp_code [aqed_lock_pkg::num_qid];
  aqed_lock_pkg::lock_res_t exp_q [$];
  int                       exp_w_q [$];
  aqed_lock_pkg::lock_key_t held_q [$];
  int errors;
  int checks;
  int failed_tests;
  int test_err_base;
  int assert_fails;
  int cycle_cnt;

  aqed_lockid_top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_we    (cfg_we),
    .cfg_wr    (cfg_wr),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .rel_valid (rel_valid),
    .rel_key   (rel_key),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  `include "aqed_lockid_model.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    for (cycle_cnt = 0; cycle_cnt < timeout_cycles; cycle_cnt++) begin
      @(posedge clk);
    end
    $display("ERROR timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] random_lockid();
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < 16; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[14:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic check_result();
    aqed_lock_pkg::lock_res_t exp;
    int w;
    assert (exp_q.size() > 0) else begin
      errors++;
      $display("ERROR t=%0t the DUT presented a result with no request outstanding", $time);
    end
    if (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      w   = exp_w_q.pop_front();
      check_val("out_res.qid", 16'(out_res.qid), 16'(exp.qid));
      check_val("out_res.lockid", out_res.lockid, exp.lockid);
      check_val("out_res.lockid upper bits", out_res.lockid >> w, 16'h0);
      check_val("out_res.busy", 16'(out_res.busy), 16'(exp.busy));
      check_val("out_res.full", 16'(out_res.full), 16'(exp.full));
    end
  endtask

  // Outputs are taken at the falling edge, then the strobes drop for the new cycle
  task automatic next_cycle();
    @(negedge clk);
    if (out_valid) begin
      check_result();
    end
    in_valid  = 1'b0;
    cfg_we    = 1'b0;
    rel_valid = 1'b0;
  endtask

  task automatic put_cfg(input logic [6:0] qid, input logic [2:0] code);
    cfg_we      = 1'b1;
    cfg_wr.qid  = qid;
    cfg_wr.code = code;
    exp_code[qid] = code;
  endtask

  // The expected flags follow the tracker rules in request order
  task automatic put_req(input logic [6:0] qid, input logic [15:0] lockid);
    aqed_lock_pkg::lock_key_t key;
    aqed_lock_pkg::lock_res_t exp;
    logic busy;
    logic full;
    key.qid    = qid;
    key.lockid = model_lockid(exp_code[qid], lockid);
    busy = 1'b0;
    foreach (held_q[i]) begin
      if (held_q[i] == key) busy = 1'b1;
    end
    full = (held_q.size() == aqed_lock_pkg::track_depth);
    if (!busy && !full) held_q.push_back(key);
    exp.qid    = key.qid;
    exp.lockid = key.lockid;
    exp.busy   = busy;
    exp.full   = full;
    exp_q.push_back(exp);
    exp_w_q.push_back((exp_code[qid] == 0) ? 16 : aqed_lock_pkg::mix_base_w + exp_code[qid]);
    in_valid      = 1'b1;
    in_req.qid    = qid;
    in_req.lockid = lockid;
  endtask

  task automatic put_rel(input aqed_lock_pkg::lock_key_t key);
    rel_valid = 1'b1;
    rel_key   = key;
    for (int i = held_q.size() - 1; i >= 0; i--) begin
      if (held_q[i] == key) held_q.delete(i);
    end
  endtask

  task automatic drain();
    next_cycle();
    while (exp_q.size() != 0) next_cycle();
  endtask

  task automatic release_all();
    aqed_lock_pkg::lock_key_t keys [$];
    keys = held_q;
    foreach (keys[i]) begin
      next_cycle();
      put_rel(keys[i]);
    end
    next_cycle();
  endtask

  task automatic end_test(input string name);
    if (errors == test_err_base) begin
      $display("test %s: passed", name);
    end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  task automatic test_passthrough();
    for (int i = 0; i < 6; i++) begin
      next_cycle();
      put_req(7'(i), (i == 0) ? 16'h0000 : (i == 1) ? 16'hffff : random_lockid());
    end
    drain();
    release_all();
    end_test("passthrough");
  endtask

  task automatic test_width_codes();
    for (int k = 1; k < 8; k++) begin
      next_cycle();
      put_cfg(7'(20 + k), 3'(k));
      for (int j = 0; j < 3; j++) begin
        next_cycle();
        put_req(7'(20 + k), random_lockid());
      end
      drain();
      release_all();
    end
    end_test("width_codes");
  endtask

  task automatic test_cfg_timing();
    logic [15:0] id_a;
    logic [15:0] id_b;
    id_a = random_lockid();
    id_b = random_lockid();
    next_cycle();
    put_cfg(7'd40, 3'd2);
    next_cycle();
    put_cfg(7'd41, 3'd5);
    next_cycle();
    put_req(7'd40, id_a);
    // A request sampled on the write edge sees the new code
    next_cycle();
    put_cfg(7'd40, 3'd6);
    put_req(7'd40, id_b);
    next_cycle();
    put_req(7'd41, id_a);
    next_cycle();
    put_req(7'd40, id_a);
    drain();
    release_all();
    end_test("cfg_timing");
  endtask

  task automatic test_back_to_back();
    logic [15:0] id;
    id = random_lockid();
    next_cycle();
    put_req(7'd70, id);
    next_cycle();
    put_req(7'd70, id);
    next_cycle();
    put_req(7'd71, id);
    drain();
    release_all();
    end_test("back_to_back");
  endtask

  task automatic test_release();
    aqed_lock_pkg::lock_key_t key;
    logic [15:0] id;
    id = random_lockid();
    key.qid    = 7'd80;
    key.lockid = model_lockid(exp_code[80], id);
    next_cycle();
    put_req(7'd80, id);
    drain();
    put_req(7'd80, id);
    drain();
    put_rel(key);
    next_cycle();
    put_req(7'd80, id);
    drain();
    release_all();
    end_test("release");
  endtask

  task automatic test_table_full();
    aqed_lock_pkg::lock_key_t key;
    for (int i = 0; i < aqed_lock_pkg::track_depth; i++) begin
      next_cycle();
      put_req(7'd90, 16'h0100 + 16'(i));
    end
    next_cycle();
    put_req(7'd90, 16'h0200);
    drain();
    key.qid    = 7'd90;
    key.lockid = 16'h0100;
    put_rel(key);
    next_cycle();
    put_req(7'd90, 16'h0200);
    drain();
    release_all();
    end_test("table_full");
  endtask

  initial begin
    arst_n    = 1'b0;
    cfg_we    = 1'b0;
    cfg_wr    = '0;
    in_valid  = 1'b0;
    in_req    = '0;
    rel_valid = 1'b0;
    rel_key   = '0;
    lfsr_state = lfsr_seed;
    errors = 0;
    checks = 0;
    failed_tests = 0;
    test_err_base = 0;
    foreach (exp_code[q]) exp_code[q] = '0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    test_passthrough();
    test_width_codes();
    test_cfg_timing();
    test_back_to_back();
    test_release();
    test_table_full();

    assert_fails = u_dut.u_assert.fail_cnt;
    $display("tests 6, failed tests %0d, checks %0d, errors %0d, assertion failures %0d",
             failed_tests, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: hdl/aqed_lock_pkg.sv
package aqed_lock_pkg;

  localparam int num_qid      = 128;
  localparam int qid_w        = 7;
  localparam int lockid_w     = 16;
  localparam int width_code_w = 3;
  localparam int crc_w        = 12;
  localparam int track_depth  = 8;

  // Flat width-code vector with three bits per QID and QID 0 in the low bits
  localparam int cfg_w = num_qid * width_code_w;

  // Width code k compresses to mix_base_w + k bits
  localparam logic [width_code_w-1:0] wcode_pass = '0;
  localparam int mix_base_w = 5;
  localparam int num_codes  = 1 << width_code_w;

  // CRC-12 over the 16-bit lock ID, one tap mask per CRC bit (bit 11 first)
  localparam logic [crc_w-1:0][lockid_w-1:0] crc_mask = {
    16'h78b1, 16'hc4e9, 16'h9ac5, 16'h35d3, 16'h6258, 16'hb12c,
    16'hd896, 16'h6c4b, 16'h4e94, 16'h274a, 16'h13a5, 16'hf163
  };

  // Mixer shifts per width code in step order
  // Steps are xor-right, xor-right, add-left, xor-right, xor-right
  localparam int unsigned mix_shift [1:num_codes-1][0:4] = '{
    '{2, 1, 3, 4, 2},
    '{1, 2, 4, 2, 3},
    '{1, 2, 4, 2, 4},
    '{1, 2, 4, 3, 5},
    '{2, 1, 5, 5, 2},
    '{1, 2, 5, 5, 3},
    '{2, 1, 5, 6, 3}
  };

  typedef struct packed {
    logic [qid_w-1:0]    qid;
    logic [lockid_w-1:0] lockid;
  } lock_req_t;

  typedef struct packed {
    logic [qid_w-1:0]    qid;
    logic [lockid_w-1:0] lockid;
    logic                busy;
    logic                full;
  } lock_res_t;

  // Lock ID here is always the compressed value
  typedef struct packed {
    logic [qid_w-1:0]    qid;
    logic [lockid_w-1:0] lockid;
  } lock_key_t;

  typedef struct packed {
    logic [qid_w-1:0]        qid;
    logic [width_code_w-1:0] code;
  } cfg_wr_t;

endpackage

// File: hdl/aqed_lock_track.sv
`timescale 1ns/1ps

module aqed_lock_track (
  input  logic                     clk,
  input  logic                     arst_n,
  input  aqed_lock_pkg::lock_key_t look_key,
  output logic                     look_busy,
  output logic                     look_full,
  input  logic                     acq_valid,
  input  aqed_lock_pkg::lock_key_t acq_key,
  input  logic                     rel_valid,
  input  aqed_lock_pkg::lock_key_t rel_key
);

  logic [aqed_lock_pkg::track_depth-1:0] ent_vld;
  aqed_lock_pkg::lock_key_t              ent_key [aqed_lock_pkg::track_depth];

  logic [aqed_lock_pkg::track_depth-1:0] rel_hit;
  logic [aqed_lock_pkg::track_depth-1:0] live;
  logic [aqed_lock_pkg::track_depth-1:0] free;
  logic [aqed_lock_pkg::track_depth-1:0] acq_sel;
  logic [aqed_lock_pkg::track_depth-1:0] look_hit;
  logic [aqed_lock_pkg::track_depth-1:0] vld_nxt;
  logic                                  acq_go;

  always_comb begin
    for (int i = 0; i < aqed_lock_pkg::track_depth; i++) begin
      rel_hit[i] = rel_valid && ent_vld[i] && (ent_key[i] == rel_key);
    end

    // Entries released this cycle already count as free
    live = ent_vld & ~rel_hit;
    free = ~live;

    // Lowest free entry, isolated as a one-hot mask
    acq_sel = free & (~free + 1'b1);
    acq_go  = acq_valid && (free != '0);
    vld_nxt = live | (acq_go ? acq_sel : '0);

    for (int i = 0; i < aqed_lock_pkg::track_depth; i++) begin
      look_hit[i] = live[i] && (ent_key[i] == look_key);
    end

    // The key being acquired right now is busy too, which catches
    // back-to-back identical requests
    look_busy = (|look_hit) || (acq_go && (acq_key == look_key));

    // Full means no slot is left once this cycle's acquire is in
    look_full = &vld_nxt;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ent_vld <= '0;
    end else begin
      ent_vld <= vld_nxt;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < aqed_lock_pkg::track_depth; i++) begin
      if (acq_go && acq_sel[i]) begin
        ent_key[i] <= acq_key;
      end
    end
  end

endmodule

// File: hdl/aqed_lockid_pipe.sv
`timescale 1ns/1ps

module aqed_lockid_pipe (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic [aqed_lock_pkg::cfg_w-1:0] cfg,
  input  logic                            in_valid,
  input  aqed_lock_pkg::lock_req_t        in_req,
  output aqed_lock_pkg::lock_key_t        look_key,
  input  logic                            look_busy,
  input  logic                            look_full,
  output logic                            acq_valid,
  output logic                            out_valid,
  output aqed_lock_pkg::lock_res_t        out_res
);

  logic                               s1_valid;
  aqed_lock_pkg::lock_req_t           s1_req;
  logic [aqed_lock_pkg::lockid_w-1:0] s1_lockid;
  logic                               s2_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_req <= in_req;
    end
  end

  // Compression and the tracker lookup both happen in stage 1
  aqed_pipe_complockid u_complockid (
    .cfg        (cfg),
    .in_lockid  (s1_req.lockid),
    .in_qid     (s1_req.qid),
    .out_lockid (s1_lockid)
  );

  assign look_key.qid    = s1_req.qid;
  assign look_key.lockid = s1_lockid;

  // Stage 2 holds the key together with the tracker's answer
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out_res.qid    <= look_key.qid;
      out_res.lockid <= look_key.lockid;
      out_res.busy   <= look_busy;
      out_res.full   <= look_full;
    end
  end

  assign out_valid = s2_valid;

  // A result that found the lock free and a slot available takes the lock
  assign acq_valid = s2_valid && !out_res.busy && !out_res.full;

endmodule

// File: hdl/aqed_lockid_top.sv
`timescale 1ns/1ps

module aqed_lockid_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     cfg_we,
  input  aqed_lock_pkg::cfg_wr_t   cfg_wr,
  input  logic                     in_valid,
  input  aqed_lock_pkg::lock_req_t in_req,
  input  logic                     rel_valid,
  input  aqed_lock_pkg::lock_key_t rel_key,
  output logic                     out_valid,
  output aqed_lock_pkg::lock_res_t out_res
);

  logic [aqed_lock_pkg::cfg_w-1:0] cfg;
  aqed_lock_pkg::lock_key_t        look_key;
  logic                            look_busy;
  logic                            look_full;
  logic                            acq_valid;
  aqed_lock_pkg::lock_key_t        acq_key;

  // The lock is acquired under the key that stage 2 presents
  assign acq_key.qid    = out_res.qid;
  assign acq_key.lockid = out_res.lockid;

  aqed_qid_width_cfg u_width_cfg (
    .clk    (clk),
    .arst_n (arst_n),
    .cfg_we (cfg_we),
    .cfg_wr (cfg_wr),
    .cfg    (cfg)
  );

  aqed_lockid_pipe u_pipe (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg       (cfg),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .look_key  (look_key),
    .look_busy (look_busy),
    .look_full (look_full),
    .acq_valid (acq_valid),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  aqed_lock_track u_track (
    .clk       (clk),
    .arst_n    (arst_n),
    .look_key  (look_key),
    .look_busy (look_busy),
    .look_full (look_full),
    .acq_valid (acq_valid),
    .acq_key   (acq_key),
    .rel_valid (rel_valid),
    .rel_key   (rel_key)
  );

endmodule

// File: hdl/aqed_pipe_complockid.sv
`timescale 1ns/1ps

module aqed_pipe_complockid (
  input  logic [aqed_lock_pkg::cfg_w-1:0]    cfg,
  input  logic [aqed_lock_pkg::lockid_w-1:0] in_lockid,
  input  logic [aqed_lock_pkg::qid_w-1:0]    in_qid,
  output logic [aqed_lock_pkg::lockid_w-1:0] out_lockid
);

  logic [aqed_lock_pkg::crc_w-1:0]        crc;
  logic [aqed_lock_pkg::width_code_w-1:0] code;

  // One candidate per width code, already zero-filled to the full lock ID width
  logic [aqed_lock_pkg::lockid_w-1:0] cand [aqed_lock_pkg::num_codes];

  // Runs the five mix steps on the low w bits of the hash
  // Right shifts stay inside w bits on their own, only the add needs the mask
  function automatic logic [aqed_lock_pkg::lockid_w-1:0] mix_hash(
    input logic [aqed_lock_pkg::crc_w-1:0] h,
    input int unsigned                     w,
    input int unsigned                     s0,
    input int unsigned                     s1,
    input int unsigned                     s2,
    input int unsigned                     s3,
    input int unsigned                     s4
  );
    logic [aqed_lock_pkg::crc_w-1:0] keep;
    logic [aqed_lock_pkg::crc_w-1:0] x;
    keep = {aqed_lock_pkg::crc_w{1'b1}} >> (aqed_lock_pkg::crc_w - w);
    x = h & keep;
    x = x ^ (x >> s0);
    x = x ^ (x >> s1);
    x = (x + (x << s2)) & keep;
    x = x ^ (x >> s3);
    x = x ^ (x >> s4);
    return {{(aqed_lock_pkg::lockid_w - aqed_lock_pkg::crc_w){1'b0}}, x};
  endfunction

  // Parallel CRC-12, each bit is the parity of the lock ID under its tap mask
  always_comb begin
    for (int i = 0; i < aqed_lock_pkg::crc_w; i++) begin
      crc[i] = ^(in_lockid & aqed_lock_pkg::crc_mask[i]);
    end
  end

  // Code 0 keeps the raw lock ID
  assign cand[aqed_lock_pkg::wcode_pass] = in_lockid;

  // Seven mixers, code k gives a 5+k bit result
  for (genvar k = 1; k < aqed_lock_pkg::num_codes; k++) begin : g_mix
    assign cand[k] = mix_hash(crc,
                              aqed_lock_pkg::mix_base_w + k,
                              aqed_lock_pkg::mix_shift[k][0],
                              aqed_lock_pkg::mix_shift[k][1],
                              aqed_lock_pkg::mix_shift[k][2],
                              aqed_lock_pkg::mix_shift[k][3],
                              aqed_lock_pkg::mix_shift[k][4]);
  end

  // Pick the mixer that the QID is configured for
  always_comb begin
    code       = cfg[in_qid*aqed_lock_pkg::width_code_w +: aqed_lock_pkg::width_code_w];
    out_lockid = cand[code];
  end

endmodule

// File: hdl/aqed_qid_width_cfg.sv
`timescale 1ns/1ps

module aqed_qid_width_cfg (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            cfg_we,
  input  aqed_lock_pkg::cfg_wr_t          cfg_wr,
  output logic [aqed_lock_pkg::cfg_w-1:0] cfg
);

  // One width code per QID
  logic [aqed_lock_pkg::width_code_w-1:0] code_q [aqed_lock_pkg::num_qid];

  // A write lands on the edge that samples cfg_we, so a request captured
  // on that same edge is compressed with the new code
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int q = 0; q < aqed_lock_pkg::num_qid; q++) begin
        code_q[q] <= '0;
      end
    end else if (cfg_we) begin
      code_q[cfg_wr.qid] <= cfg_wr.code;
    end
  end

  // The compressor indexes this vector by QID
  always_comb begin
    for (int q = 0; q < aqed_lock_pkg::num_qid; q++) begin
      cfg[q*aqed_lock_pkg::width_code_w +: aqed_lock_pkg::width_code_w] = code_q[q];
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module aqed_lockid_tb -f tb.f -o aqed_lockid_sim

./obj_dir/aqed_lockid_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// File: tb.f
+incdir+include
hdl/aqed_lock_pkg.sv
hdl/aqed_qid_width_cfg.sv
hdl/aqed_pipe_complockid.sv
hdl/aqed_lockid_pipe.sv
hdl/aqed_lock_track.sv
hdl/aqed_lockid_top.sv
dv/aqed_lockid_assert.sv
dv/aqed_lockid_tb.sv
